// ==== shell_pkg.sv ====
/*
  Shared widths, register map and boot encodings of the board shell.
  The register map assumes a 4-bit word address and a 32-bit data bus.
*/
package shell_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus and pad widths
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned WbAddrWidth   = 4;
  localparam int unsigned WbDataWidth   = 32;
  localparam int unsigned FanLevelWidth = 4;
  localparam int unsigned NumSpiCs      = 2;
  localparam int unsigned SpiDataWidth  = 4;

  // Read-only identification word
  localparam logic [WbDataWidth-1:0] ShellId = 32'h5E11_0001;

  //////////////////////////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////////////////////////

  // Word addresses of the register block
  typedef enum logic [WbAddrWidth-1:0] {
    RegId     = 4'd0,
    RegBoot   = 4'd1,
    RegFan    = 4'd2,
    RegStatus = 4'd3
  } reg_addr_e;

  // Boot source handed to the SoC
  typedef enum logic [1:0] {
    BootPassive  = 2'd0,
    BootSpiSd    = 2'd1,
    BootSpiFlash = 2'd2,
    BootUart     = 2'd3
  } boot_mode_e;

endpackage

// ==== rst_sync.sv ====
/*
  Reset synchronizer. Assertion is asynchronous, release takes two soc_clk edges.
  In test mode the raw board reset passes straight through for scan.
*/
`timescale 1ns/100ps

module rst_sync (
  input  logic soc_clk,
  input  logic rst_n,
  input  logic test_mode_i,
  output logic rst_sync_n_o
);

  logic [1:0] sync_q;

  // Chain clears at once and fills with ones after release
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  // Scan needs direct control of reset
  assign rst_sync_n_o = test_mode_i ? rst_n : sync_q[1];

  // Release is never earlier than two edges after the board reset rises
  a_release_late: assert property (
    @(posedge soc_clk) disable iff (test_mode_i)
    $rose(rst_sync_n_o) |-> $past(rst_n, 2)
  );

endmodule

// ==== rtc_divider.sv ====
/*
  Square-wave RTC from soc_clk. Period is exactly 2 * RtcHalfDiv cycles.
  RtcHalfDiv must be at least 1.
*/
`timescale 1ns/100ps

module rtc_divider #(
  parameter int unsigned RtcHalfDiv = 25
) (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_clk_o
);

  localparam int unsigned CntWidth = (RtcHalfDiv > 1) ? $clog2(RtcHalfDiv) : 1;
  localparam logic [CntWidth-1:0] CntLast = CntWidth'(RtcHalfDiv - 1);

  logic [CntWidth-1:0] cnt_q;
  logic                rtc_q;

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
      rtc_q <= 1'b0;
    end else if (cnt_q == CntLast) begin
      cnt_q <= '0;
      rtc_q <= ~rtc_q;
    end else begin
      cnt_q <= cnt_q + CntWidth'(1);
    end
  end

  assign rtc_clk_o = rtc_q;

  a_cnt_range: assert property (
    @(posedge soc_clk) disable iff (!rst_n) cnt_q <= CntLast
  );

endmodule

// ==== fan_pwm.sv ====
/*
  Sixteen-slot fan PWM, each slot PwmPrescale cycles long.
  The level is taken once per period, so 100% duty is not reachable.
*/
`timescale 1ns/100ps

module fan_pwm #(
  parameter int unsigned PwmPrescale = 64
) (
  input  logic                                soc_clk,
  input  logic                                rst_n,
  input  logic [shell_pkg::FanLevelWidth-1:0] level_i,
  output logic                                fan_pwm_o
);

  localparam int unsigned PreWidth = (PwmPrescale > 1) ? $clog2(PwmPrescale) : 1;
  localparam logic [PreWidth-1:0] PreLast = PreWidth'(PwmPrescale - 1);

  logic [PreWidth-1:0]                 pre_q;
  logic [shell_pkg::FanLevelWidth-1:0] slot_q;
  logic [shell_pkg::FanLevelWidth-1:0] level_q;
  logic                                slot_end;
  logic                                period_end;
  logic                                pwm_q;

  assign slot_end   = (pre_q == PreLast);
  assign period_end = slot_end && (slot_q == '1);

  // Counters start at the last slot so the first edge opens a period
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      pre_q   <= PreLast;
      slot_q  <= '1;
      level_q <= '0;
      pwm_q   <= 1'b0;
    end else begin
      pre_q <= slot_end ? '0 : pre_q + PreWidth'(1);
      if (slot_end) begin
        slot_q <= slot_q + 1'b1;
      end
      if (period_end) begin
        level_q <= level_i;
      end
      // High for the first level slots of the period
      pwm_q <= (slot_q < level_q);
    end
  end

  assign fan_pwm_o = pwm_q;

  a_zero_level_off: assert property (
    @(posedge soc_clk) disable iff (!rst_n) (level_q == '0) |-> !fan_pwm_o
  );

endmodule

// ==== spi_pad_mux.sv ====
/*
  Combinational SPI pad routing. Chip select 0 is the SD slot, 1 the QSPI flash.
  Pads are split into output, output-enable and input ports.
*/
`timescale 1ns/100ps

module spi_pad_mux (
  // SoC SPI host side
  input  logic                               soc_sck_i,
  input  logic                               soc_sck_en_i,
  input  logic [shell_pkg::NumSpiCs-1:0]     soc_csb_i,
  input  logic [shell_pkg::NumSpiCs-1:0]     soc_csb_en_i,
  input  logic [shell_pkg::SpiDataWidth-1:0] soc_sd_i,
  input  logic [shell_pkg::SpiDataWidth-1:0] soc_sd_en_i,
  output logic [shell_pkg::SpiDataWidth-1:0] soc_sd_o,
  // SD card slot in SPI mode
  output logic                               sd_sclk_o,
  output logic                               sd_dat3_o,
  output logic                               sd_cmd_o,
  output logic [1:0]                         sd_dat12_o,
  input  logic                               sd_dat0_i,
  // Quad-SPI flash
  output logic                               flash_sck_o,
  output logic                               flash_sck_oe_o,
  output logic                               flash_csb_o,
  output logic                               flash_csb_oe_o,
  output logic [shell_pkg::SpiDataWidth-1:0] flash_sd_o,
  output logic [shell_pkg::SpiDataWidth-1:0] flash_sd_oe_o,
  input  logic [shell_pkg::SpiDataWidth-1:0] flash_sd_i
);

  logic [shell_pkg::SpiDataWidth-1:0] sd_in;

  // SD pins idle high when the host does not drive them
  assign sd_sclk_o  = soc_sck_en_i    ? soc_sck_i    : 1'b1;
  assign sd_dat3_o  = soc_csb_en_i[0] ? soc_csb_i[0] : 1'b1;
  assign sd_cmd_o   = soc_sd_en_i[0]  ? soc_sd_i[0]  : 1'b1;
  assign sd_dat12_o = 2'b11;

  // MISO of the card lands on data line 1
  assign sd_in = {2'b00, sd_dat0_i, 1'b0};

  // Flash follows the host directly
  assign flash_sck_o    = soc_sck_i;
  assign flash_sck_oe_o = soc_sck_en_i;
  assign flash_csb_o    = soc_csb_i[1];
  assign flash_csb_oe_o = soc_csb_en_i[1];
  assign flash_sd_o     = soc_sd_i;
  assign flash_sd_oe_o  = soc_sd_en_i;

  // Input merge by active-low chip select
  assign soc_sd_o = ({shell_pkg::SpiDataWidth{~soc_csb_i[0]}} & sd_in) |
                    ({shell_pkg::SpiDataWidth{~soc_csb_i[1]}} & flash_sd_i);

  // Both devices selected would short their MISO lines on the SoC side
  a_cs_exclusive: assert final (
    $isunknown({soc_csb_i, soc_csb_en_i}) ||
    !(soc_csb_en_i[0] && !soc_csb_i[0] && soc_csb_en_i[1] && !soc_csb_i[1])
  );

endmodule

// ==== shell_regs.sv ====
/*
  Wishbone classic register block with a one-cycle reply. The master must drop stb
  after ack or err, else a second reply follows. Bad address or read-only write errs.
*/
`timescale 1ns/100ps

module shell_regs (
  input  logic                                soc_clk,
  input  logic                                rst_n,
  // Wishbone classic slave
  input  logic                                wb_cyc_i,
  input  logic                                wb_stb_i,
  input  logic                                wb_we_i,
  input  logic [shell_pkg::WbAddrWidth-1:0]   wb_adr_i,
  input  logic [shell_pkg::WbDataWidth-1:0]   wb_dat_i,
  output logic [shell_pkg::WbDataWidth-1:0]   wb_dat_o,
  output logic                                wb_ack_o,
  output logic                                wb_err_o,
  // Board inputs and effective settings
  input  logic [1:0]                          boot_sw_i,
  input  logic [shell_pkg::FanLevelWidth-1:0] fan_sw_i,
  input  logic                                test_mode_i,
  output shell_pkg::boot_mode_e               boot_mode_o,
  output logic [shell_pkg::FanLevelWidth-1:0] fan_level_o
);

  logic                                req;
  logic                                ack_d;
  logic                                err_d;
  logic                                ack_q;
  logic                                err_q;
  logic                                boot_wr;
  logic                                fan_wr;
  logic [shell_pkg::WbDataWidth-1:0]   status;
  logic [shell_pkg::WbDataWidth-1:0]   rdata_d;
  logic [shell_pkg::WbDataWidth-1:0]   rdata_q;
  shell_pkg::boot_mode_e               boot_val_q;
  logic                                boot_sel_q;
  logic [shell_pkg::FanLevelWidth-1:0] fan_lvl_q;
  logic                                fan_en_q;

  //////////////////////////////////////////////////////////////////////
  // Request decode
  //////////////////////////////////////////////////////////////////////

  // No new request while a reply is on the bus
  assign req = wb_cyc_i && wb_stb_i && !ack_q && !err_q;

  assign status = {24'b0, fan_level_o, 1'b0, test_mode_i, boot_mode_o};

  always_comb begin
    ack_d   = 1'b0;
    err_d   = 1'b0;
    boot_wr = 1'b0;
    fan_wr  = 1'b0;
    rdata_d = '0;
    if (req) begin
      ack_d = 1'b1;
      case (shell_pkg::reg_addr_e'(wb_adr_i))
        shell_pkg::RegId: begin
          rdata_d = shell_pkg::ShellId;
          err_d   = wb_we_i;
        end
        shell_pkg::RegBoot: begin
          rdata_d = {29'b0, boot_sel_q, boot_val_q};
          boot_wr = wb_we_i;
        end
        shell_pkg::RegFan: begin
          rdata_d = {27'b0, fan_en_q, fan_lvl_q};
          fan_wr  = wb_we_i;
        end
        shell_pkg::RegStatus: begin
          rdata_d = status;
          err_d   = wb_we_i;
        end
        default: err_d = 1'b1;
      endcase
      if (err_d) begin
        ack_d   = 1'b0;
        rdata_d = '0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // State
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q      <= 1'b0;
      err_q      <= 1'b0;
      rdata_q    <= '0;
      boot_val_q <= shell_pkg::BootPassive;
      boot_sel_q <= 1'b0;
      fan_lvl_q  <= '0;
      fan_en_q   <= 1'b0;
    end else begin
      ack_q   <= ack_d;
      err_q   <= err_d;
      rdata_q <= rdata_d;
      if (boot_wr) begin
        boot_val_q <= shell_pkg::boot_mode_e'(wb_dat_i[1:0]);
        boot_sel_q <= wb_dat_i[2];
      end
      if (fan_wr) begin
        fan_lvl_q <= wb_dat_i[3:0];
        fan_en_q  <= wb_dat_i[4];
      end
    end
  end

  assign wb_ack_o = ack_q;
  assign wb_err_o = err_q;
  assign wb_dat_o = rdata_q;

  // Overrides win over the board switches
  assign boot_mode_o = boot_sel_q ? boot_val_q : shell_pkg::boot_mode_e'(boot_sw_i);
  assign fan_level_o = fan_en_q ? fan_lvl_q : fan_sw_i;

  a_one_reply: assert property (
    @(posedge soc_clk) disable iff (!rst_n) !(wb_ack_o && wb_err_o)
  );

  a_reply_needs_req: assert property (
    @(posedge soc_clk) disable iff (!rst_n)
    (wb_ack_o || wb_err_o) |-> $past(wb_cyc_i && wb_stb_i)
  );

endmodule

// ==== board_shell_top.sv ====
/*
  Board shell between FPGA pins and the SoC core. The register bus stands in for
  the SoC, and all pads are split into separate in, out and enable ports.
*/
`timescale 1ns/100ps

module board_shell_top #(
  parameter int unsigned RtcHalfDiv  = 25,
  parameter int unsigned PwmPrescale = 64
) (
  input  logic                                soc_clk,
  input  logic                                rst_n,
  input  logic                                test_mode_i,
  input  logic [1:0]                          boot_sw_i,
  input  logic [shell_pkg::FanLevelWidth-1:0] fan_sw_i,
  // Register bus
  input  logic                                wb_cyc_i,
  input  logic                                wb_stb_i,
  input  logic                                wb_we_i,
  input  logic [shell_pkg::WbAddrWidth-1:0]   wb_adr_i,
  input  logic [shell_pkg::WbDataWidth-1:0]   wb_dat_i,
  output logic [shell_pkg::WbDataWidth-1:0]   wb_dat_o,
  output logic                                wb_ack_o,
  output logic                                wb_err_o,
  // To the SoC and board
  output shell_pkg::boot_mode_e               boot_mode_o,
  output logic                                rtc_clk_o,
  output logic                                fan_pwm_o,
  // SoC SPI host
  input  logic                                soc_sck_i,
  input  logic                                soc_sck_en_i,
  input  logic [shell_pkg::NumSpiCs-1:0]      soc_csb_i,
  input  logic [shell_pkg::NumSpiCs-1:0]      soc_csb_en_i,
  input  logic [shell_pkg::SpiDataWidth-1:0]  soc_sd_i,
  input  logic [shell_pkg::SpiDataWidth-1:0]  soc_sd_en_i,
  output logic [shell_pkg::SpiDataWidth-1:0]  soc_sd_o,
  // SD slot pads
  output logic                                sd_sclk_o,
  output logic                                sd_dat3_o,
  output logic                                sd_cmd_o,
  output logic [1:0]                          sd_dat12_o,
  input  logic                                sd_dat0_i,
  // Flash pads
  output logic                                flash_sck_o,
  output logic                                flash_sck_oe_o,
  output logic                                flash_csb_o,
  output logic                                flash_csb_oe_o,
  output logic [shell_pkg::SpiDataWidth-1:0]  flash_sd_o,
  output logic [shell_pkg::SpiDataWidth-1:0]  flash_sd_oe_o,
  input  logic [shell_pkg::SpiDataWidth-1:0]  flash_sd_i
);

  logic                                rst_sync_n;
  logic [shell_pkg::FanLevelWidth-1:0] fan_level;

  //////////////////////////////////////////////////////////////////////
  // Reset and registers
  //////////////////////////////////////////////////////////////////////

  rst_sync u_rst_sync (
    .soc_clk      ( soc_clk     ),
    .rst_n        ( rst_n       ),
    .test_mode_i  ( test_mode_i ),
    .rst_sync_n_o ( rst_sync_n  )
  );

  shell_regs u_shell_regs (
    .soc_clk     ( soc_clk     ),
    .rst_n       ( rst_sync_n  ),
    .wb_cyc_i    ( wb_cyc_i    ),
    .wb_stb_i    ( wb_stb_i    ),
    .wb_we_i     ( wb_we_i     ),
    .wb_adr_i    ( wb_adr_i    ),
    .wb_dat_i    ( wb_dat_i    ),
    .wb_dat_o    ( wb_dat_o    ),
    .wb_ack_o    ( wb_ack_o    ),
    .wb_err_o    ( wb_err_o    ),
    .boot_sw_i   ( boot_sw_i   ),
    .fan_sw_i    ( fan_sw_i    ),
    .test_mode_i ( test_mode_i ),
    .boot_mode_o ( boot_mode_o ),
    .fan_level_o ( fan_level   )
  );

  //////////////////////////////////////////////////////////////////////
  // Timers
  //////////////////////////////////////////////////////////////////////

  rtc_divider #(
    .RtcHalfDiv ( RtcHalfDiv )
  ) u_rtc_divider (
    .soc_clk   ( soc_clk    ),
    .rst_n     ( rst_sync_n ),
    .rtc_clk_o ( rtc_clk_o  )
  );

  fan_pwm #(
    .PwmPrescale ( PwmPrescale )
  ) u_fan_pwm (
    .soc_clk   ( soc_clk    ),
    .rst_n     ( rst_sync_n ),
    .level_i   ( fan_level  ),
    .fan_pwm_o ( fan_pwm_o  )
  );

  // SD on chip select 0, flash on chip select 1
  spi_pad_mux u_spi_pad_mux (
    .soc_sck_i      ( soc_sck_i      ),
    .soc_sck_en_i   ( soc_sck_en_i   ),
    .soc_csb_i      ( soc_csb_i      ),
    .soc_csb_en_i   ( soc_csb_en_i   ),
    .soc_sd_i       ( soc_sd_i       ),
    .soc_sd_en_i    ( soc_sd_en_i    ),
    .soc_sd_o       ( soc_sd_o       ),
    .sd_sclk_o      ( sd_sclk_o      ),
    .sd_dat3_o      ( sd_dat3_o      ),
    .sd_cmd_o       ( sd_cmd_o       ),
    .sd_dat12_o     ( sd_dat12_o     ),
    .sd_dat0_i      ( sd_dat0_i      ),
    .flash_sck_o    ( flash_sck_o    ),
    .flash_sck_oe_o ( flash_sck_oe_o ),
    .flash_csb_o    ( flash_csb_o    ),
    .flash_csb_oe_o ( flash_csb_oe_o ),
    .flash_sd_o     ( flash_sd_o     ),
    .flash_sd_oe_o  ( flash_sd_oe_o  ),
    .flash_sd_i     ( flash_sd_i     )
  );

endmodule

// ==== tb_board_shell.sv ====
/*
  Table-driven testbench for the board shell. Runs with RtcHalfDiv 5 and PwmPrescale 2.
  Inputs change on the rising edge and outputs are sampled on the falling edge.
*/
`timescale 1ns/100ps

module tb_board_shell;

  localparam int unsigned RtcHalf = 5;
  localparam int unsigned PwmPre  = 2;

  typedef enum {OpRead, OpWrite, OpSwitch, OpRtc, OpPwm, OpSpi} op_e;

  logic                                soc_clk;
  logic                                rst_n;
  logic                                test_mode_i;
  logic [1:0]                          boot_sw_i;
  logic [shell_pkg::FanLevelWidth-1:0] fan_sw_i;
  logic                                wb_cyc_i;
  logic                                wb_stb_i;
  logic                                wb_we_i;
  logic [shell_pkg::WbAddrWidth-1:0]   wb_adr_i;
  logic [shell_pkg::WbDataWidth-1:0]   wb_dat_i;
  logic [shell_pkg::WbDataWidth-1:0]   wb_dat_o;
  logic                                wb_ack_o;
  logic                                wb_err_o;
  shell_pkg::boot_mode_e               boot_mode_o;
  logic                                rtc_clk_o;
  logic                                fan_pwm_o;
  logic                                soc_sck_i;
  logic                                soc_sck_en_i;
  logic [shell_pkg::NumSpiCs-1:0]      soc_csb_i;
  logic [shell_pkg::NumSpiCs-1:0]      soc_csb_en_i;
  logic [shell_pkg::SpiDataWidth-1:0]  soc_sd_i;
  logic [shell_pkg::SpiDataWidth-1:0]  soc_sd_en_i;
  logic [shell_pkg::SpiDataWidth-1:0]  soc_sd_o;
  logic                                sd_sclk_o;
  logic                                sd_dat3_o;
  logic                                sd_cmd_o;
  logic [1:0]                          sd_dat12_o;
  logic                                sd_dat0_i;
  logic                                flash_sck_o;
  logic                                flash_sck_oe_o;
  logic                                flash_csb_o;
  logic                                flash_csb_oe_o;
  logic [shell_pkg::SpiDataWidth-1:0]  flash_sd_o;
  logic [shell_pkg::SpiDataWidth-1:0]  flash_sd_oe_o;
  logic [shell_pkg::SpiDataWidth-1:0]  flash_sd_i;

  // Stimulus table, one queue per column
  string       name_q[$];
  op_e         op_q[$];
  logic [3:0]  addr_q[$];
  logic [31:0] wdata_q[$];
  logic [31:0] exp_q[$];
  logic        exp_err_q[$];

  int          errors;
  int unsigned cycles;
  int unsigned limit;
  int unsigned seed_val;

  board_shell_top #(
    .RtcHalfDiv  ( RtcHalf ),
    .PwmPrescale ( PwmPre  )
  ) u_board_shell_top (.*);

  initial begin
    soc_clk = 1'b0;
    forever #50 soc_clk = ~soc_clk;
  end

  // Run limit is armed once the table is built
  always @(posedge soc_clk) begin
    cycles = cycles + 1;
    if (limit != 0 && cycles >= limit) begin
      $display("Timeout: run still busy after %0d cycles", cycles);
      $display("Errors found");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic add_entry(input string name, input op_e op, input logic [3:0] addr,
                           input logic [31:0] wdata, input logic [31:0] exp,
                           input logic exp_err);
    name_q.push_back(name);
    op_q.push_back(op);
    addr_q.push_back(addr);
    wdata_q.push_back(wdata);
    exp_q.push_back(exp);
    exp_err_q.push_back(exp_err);
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic bus_access(input string name, input logic we, input logic [3:0] adr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int   n;
    logic got;
    got   = 1'b0;
    rdata = '0;
    err   = 1'b0;
    @(posedge soc_clk);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= adr;
    wb_dat_i <= wdata;
    for (n = 0; n < 4 && !got; n++) begin
      @(negedge soc_clk);
      if (wb_ack_o || wb_err_o) begin
        got   = 1'b1;
        rdata = wb_dat_o;
        err   = wb_err_o;
      end
    end
    @(posedge soc_clk);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
    assert (got) else begin
      $display("%s: no bus reply within 4 cycles", name);
      errors++;
    end
  endtask

  // Cycles until the next rising edge of the RTC output or -1 if none
  task automatic wait_rtc_rise(output int rise_at);
    int   n;
    logic prev;
    rise_at = -1;
    prev    = rtc_clk_o;
    for (n = 1; n <= 4 * RtcHalf && rise_at < 0; n++) begin
      @(negedge soc_clk);
      if (rtc_clk_o && !prev) rise_at = n;
      prev = rtc_clk_o;
    end
  endtask

  // Settle past one full period so the new level is latched before counting
  task automatic measure_pwm(output int high);
    int n;
    high = 0;
    repeat (16 * PwmPre + 2) @(negedge soc_clk);
    for (n = 0; n < 16 * PwmPre; n++) begin
      @(negedge soc_clk);
      if (fan_pwm_o) high++;
    end
  endtask

  // Mode 0 selects the SD card and 1 the flash while any other mode leaves the bus idle
  task automatic spi_check(input string name, input logic [3:0] mode);
    logic [31:0] r;
    r = $urandom;
    @(posedge soc_clk);
    soc_sck_i  <= r[0];
    soc_sd_i   <= r[7:4];
    flash_sd_i <= r[15:12];
    sd_dat0_i  <= r[16];
    if (mode == 4'd0) begin
      soc_sck_en_i <= 1'b1;
      soc_csb_i    <= 2'b10;
      soc_csb_en_i <= 2'b11;
      soc_sd_en_i  <= r[11:8] | 4'b0001;
    end else if (mode == 4'd1) begin
      soc_sck_en_i <= r[1];
      soc_csb_i    <= 2'b01;
      soc_csb_en_i <= 2'b11;
      soc_sd_en_i  <= r[11:8];
    end else begin
      soc_sck_en_i <= 1'b0;
      soc_csb_i    <= 2'b11;
      soc_csb_en_i <= 2'b00;
      soc_sd_en_i  <= 4'b0000;
    end
    @(negedge soc_clk);
    if (mode == 4'd0) begin
      check_val({name, " sd_sclk"}, r[0], sd_sclk_o);
      check_val({name, " sd_dat3"}, 1'b0, sd_dat3_o);
      check_val({name, " sd_cmd"}, r[4], sd_cmd_o);
      check_val({name, " soc_sd"}, {2'b00, r[16], 1'b0}, soc_sd_o);
    end else if (mode == 4'd1) begin
      check_val({name, " flash_sck"}, {r[1], r[0]}, {flash_sck_oe_o, flash_sck_o});
      check_val({name, " flash_csb"}, 2'b10, {flash_csb_oe_o, flash_csb_o});
      check_val({name, " flash_sd"}, r[7:4], flash_sd_o);
      check_val({name, " flash_sd_oe"}, r[11:8], flash_sd_oe_o);
      check_val({name, " soc_sd"}, r[15:12], soc_sd_o);
    end else begin
      check_val({name, " sd_idle"}, 3'b111, {sd_sclk_o, sd_dat3_o, sd_cmd_o});
      check_val({name, " soc_sd"}, 4'b0000, soc_sd_o);
    end
    check_val({name, " sd_dat12"}, 2'b11, sd_dat12_o);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int          i;
    int          meas;
    logic [31:0] rdata;
    logic        rerr;
    errors   = 0;
    cycles   = 0;
    limit    = 0;
    seed_val = $urandom(50842);
    rst_n = 1'b0;
    test_mode_i = 1'b0;
    boot_sw_i = 2'b00;
    fan_sw_i = '0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    soc_sck_i = 1'b0;
    soc_sck_en_i = 1'b0;
    soc_csb_i = 2'b11;
    soc_csb_en_i = 2'b00;
    soc_sd_i = '0;
    soc_sd_en_i = '0;
    sd_dat0_i = 1'b0;
    flash_sd_i = '0;

    // Switch entries carry boot in wdata bits 1:0, fan level in 7:4 and test mode in 8
    add_entry("id_read", OpRead, 4'd0, 32'h0, shell_pkg::ShellId, 1'b0);
    add_entry("bad_addr_read", OpRead, 4'd7, 32'h0, 32'h0, 1'b1);
    add_entry("status_write", OpWrite, 4'd3, 32'hFF, 32'h0, 1'b1);
    add_entry("status_after_err", OpRead, 4'd3, 32'h0, 32'h00, 1'b0);
    add_entry("rtc_period", OpRtc, 4'd0, 32'h0, 2 * RtcHalf, 1'b0);
    add_entry("boot_sw_sd", OpSwitch, 4'd0, 32'h001, 32'd1, 1'b0);
    add_entry("status_boot_sd", OpRead, 4'd3, 32'h0, 32'h01, 1'b0);
    add_entry("boot_sw_uart", OpSwitch, 4'd0, 32'h003, 32'd3, 1'b0);
    add_entry("status_boot_uart", OpRead, 4'd3, 32'h0, 32'h03, 1'b0);
    add_entry("boot_override_write", OpWrite, 4'd1, 32'h6, 32'h0, 1'b0);
    add_entry("boot_override_pin", OpSwitch, 4'd0, 32'h103, 32'd2, 1'b0);
    add_entry("status_override", OpRead, 4'd3, 32'h0, 32'h06, 1'b0);
    add_entry("boot_reg_read", OpRead, 4'd1, 32'h0, 32'h06, 1'b0);
    add_entry("fan_sw_5", OpSwitch, 4'd0, 32'h153, 32'd2, 1'b0);
    add_entry("pwm_level_5", OpPwm, 4'd0, 32'h0, 5 * PwmPre, 1'b0);
    add_entry("status_fan_5", OpRead, 4'd3, 32'h0, 32'h56, 1'b0);
    add_entry("fan_sw_15", OpSwitch, 4'd0, 32'h1F3, 32'd2, 1'b0);
    add_entry("pwm_level_15", OpPwm, 4'd0, 32'h0, 15 * PwmPre, 1'b0);
    add_entry("fan_sw_0", OpSwitch, 4'd0, 32'h003, 32'd2, 1'b0);
    add_entry("pwm_level_0", OpPwm, 4'd0, 32'h0, 0, 1'b0);
    add_entry("fan_override_write", OpWrite, 4'd2, 32'h19, 32'h0, 1'b0);
    add_entry("pwm_override_9", OpPwm, 4'd0, 32'h0, 9 * PwmPre, 1'b0);
    add_entry("status_fan_9", OpRead, 4'd3, 32'h0, 32'h92, 1'b0);
    add_entry("fan_reg_read", OpRead, 4'd2, 32'h0, 32'h19, 1'b0);
    add_entry("spi_sd_a", OpSpi, 4'd0, 32'h0, 32'h0, 1'b0);
    add_entry("spi_flash_a", OpSpi, 4'd1, 32'h0, 32'h0, 1'b0);
    add_entry("spi_idle", OpSpi, 4'd2, 32'h0, 32'h0, 1'b0);
    add_entry("spi_sd_b", OpSpi, 4'd0, 32'h0, 32'h0, 1'b0);
    add_entry("spi_flash_b", OpSpi, 4'd1, 32'h0, 32'h0, 1'b0);
    limit = name_q.size() * 8 + 6 * 32 + 200;

    repeat (5) @(posedge soc_clk);
    rst_n <= 1'b1;
    // Two edges for the synchronizer and one to spare
    repeat (3) @(posedge soc_clk);
    @(negedge soc_clk);
    check_val("reset_outputs", 4'b0000, {wb_ack_o, wb_err_o, rtc_clk_o, fan_pwm_o});

    for (i = 0; i < name_q.size(); i++) begin
      case (op_q[i])
        OpRead, OpWrite: begin
          bus_access(name_q[i], op_q[i] == OpWrite, addr_q[i], wdata_q[i], rdata, rerr);
          check_val({name_q[i], " err"}, exp_err_q[i], rerr);
          if (op_q[i] == OpRead && !exp_err_q[i]) begin
            check_val({name_q[i], " data"}, exp_q[i], rdata);
          end
        end
        OpSwitch: begin
          @(posedge soc_clk);
          boot_sw_i   <= wdata_q[i][1:0];
          fan_sw_i    <= wdata_q[i][7:4];
          test_mode_i <= wdata_q[i][8];
          @(negedge soc_clk);
          check_val({name_q[i], " boot_mode"}, exp_q[i], boot_mode_o);
        end
        OpRtc: begin
          @(negedge soc_clk);
          wait_rtc_rise(meas);
          wait_rtc_rise(meas);
          check_val(name_q[i], exp_q[i], meas);
        end
        OpPwm: begin
          measure_pwm(meas);
          check_val(name_q[i], exp_q[i], meas);
        end
        default: spi_check(name_q[i], addr_q[i]);
      endcase
    end

    $display("Error count: %0d", errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== build.f ====
shell_pkg.sv
rst_sync.sv
rtc_divider.sv
fan_pwm.sv
spi_pad_mux.sv
shell_regs.sv
board_shell_top.sv
tb_board_shell.sv

// ==== Bender.yml ====
package:
  name: board_shell

sources:
  - shell_pkg.sv
  - rst_sync.sv
  - rtc_divider.sv
  - fan_pwm.sv
  - spi_pad_mux.sv
  - shell_regs.sv
  - board_shell_top.sv
  - target: test
    files:
      - tb_board_shell.sv
